// ==== design/conv_in_pkg.sv ====
`default_nettype none

package conv_in_pkg;

  // Array sizes.
  localparam int word_width   = 8;
  localparam int units        = 2;
  localparam int kernel_h_max = 3;
  localparam int units_edges  = units + kernel_h_max - 1;  // Words in one input pixel beat.
  localparam int cores        = 2;
  localparam int kernel_w_max = 3;
  localparam int w_beat_words = cores * kernel_w_max;
  localparam int cin_max      = 8;
  localparam int w_depth      = kernel_h_max * cin_max;    // Rows held by the weight buffer.

  localparam int kh_bits     = 2;
  localparam int cin_bits    = 4;
  localparam int w_addr_bits = $clog2(w_depth);

  // Pixel header layout.
  localparam int im_hdr_kh_word   = 0;
  localparam int im_hdr_flag_word = 1;
  localparam int im_hdr_max_bit   = 0;
  localparam int im_hdr_lrelu_bit = 1;

  typedef logic [word_width-1:0] word_t;

  typedef word_t [units_edges-1:0]  pix_in_t;   // Word i sits at index i.
  typedef word_t [units-1:0]        pix_out_t;
  typedef word_t [w_beat_words-1:0] w_beat_t;

  typedef logic [kh_bits-1:0]     kh_t;
  typedef logic [cin_bits-1:0]    cin_t;
  typedef logic [w_addr_bits-1:0] w_addr_t;

  typedef struct packed {
    kh_t  kernel_h;
    logic is_max;
    logic is_lrelu;
  } im_cfg_t;

  typedef struct packed {
    logic is_max;
    logic is_lrelu;
    logic is_1x1;
    logic is_cin_last;
    kh_t  kh_idx;
  } conv_user_t;

  // Weight header beat, viewed over a full w_beat_t with word 0 at the bottom.
  typedef struct packed {
    word_t [w_beat_words-3:0] rsvd;
    word_t                    kernel_h;
    word_t                    cin;
  } w_hdr_t;

endpackage

`default_nettype wire

// ==== design/im_shifter.sv ====
`default_nettype none

module im_shifter #(
  parameter bit has_header = 1'b1
) (
  input  wire logic                 aclk,
  input  wire logic                 rst,
  input  wire logic                 s_tvalid,
  output logic                      s_tready,
  input  wire logic                 s_tlast,
  input  wire conv_in_pkg::pix_in_t s_tdata,
  input  wire conv_in_pkg::im_cfg_t cfg_in,
  output logic                      m_tvalid,
  input  wire logic                 m_tready,
  output conv_in_pkg::pix_out_t     m_tdata,
  output conv_in_pkg::kh_t          m_kh_idx,
  output logic                      m_last,
  output conv_in_pkg::im_cfg_t      cfg_out
);

  logic                 ready_en;
  logic                 arm_q;      // At an image boundary, before the first data beat.
  logic                 pending;    // Rows of the held beat still to be emitted.
  logic                 last_q;
  conv_in_pkg::pix_in_t beat_q;
  conv_in_pkg::kh_t     kh_q;       // Kernel height latched with the held beat.
  conv_in_pkg::kh_t     row_q;
  conv_in_pkg::im_cfg_t cfg_q;
  conv_in_pkg::kh_t     kh_live;
  logic                 out_free;
  logic                 s_fire;
  logic                 data_fire;
  logic                 load_next;
  logic                 final_row;

  // Picks the units-wide window for one kernel row, centred for smaller kernels.
  function automatic conv_in_pkg::pix_out_t window(input conv_in_pkg::pix_in_t beat,
                                                   input conv_in_pkg::kh_t     kh,
                                                   input conv_in_pkg::kh_t     row);
    conv_in_pkg::pix_out_t rows;
    int                    base;
    base = (conv_in_pkg::kernel_h_max - int'(kh)) / 2 + int'(row);
    for (int u = 0; u < conv_in_pkg::units; u++) begin
      rows[u] = beat[base + u];
    end
    return rows;
  endfunction

  assign kh_live   = has_header ? cfg_q.kernel_h : cfg_in.kernel_h;
  assign cfg_out   = cfg_q;
  assign out_free  = !m_tvalid || m_tready;
  assign final_row = (row_q == kh_q - 1'b1);
  assign load_next = pending && out_free;

  // A header is only taken once the last row of the previous image has left.
  assign s_tready  = ready_en && !pending &&
                     (arm_q ? (has_header && !m_tvalid) : out_free);
  assign s_fire    = s_tvalid && s_tready;
  assign data_fire = s_fire && !arm_q;

  always_ff @(posedge aclk) begin
    if (rst) begin
      ready_en <= 1'b0;
      arm_q    <= 1'b1;
      pending  <= 1'b0;
      m_tvalid <= 1'b0;
      row_q    <= '0;
      kh_q     <= '0;
      last_q   <= 1'b0;
      cfg_q    <= '0;
    end else begin
      ready_en <= 1'b1;
      if (data_fire) begin
        m_tvalid <= 1'b1;
        kh_q     <= kh_live;
        last_q   <= s_tlast;
        row_q    <= conv_in_pkg::kh_t'(1);
        pending  <= (kh_live != conv_in_pkg::kh_t'(1));
        arm_q    <= s_tlast && (kh_live == conv_in_pkg::kh_t'(1));
      end else if (load_next) begin
        m_tvalid <= 1'b1;
        row_q    <= row_q + 1'b1;
        if (final_row) begin
          pending <= 1'b0;
          arm_q   <= last_q;  // Re-arm after the final row of the image.
        end
      end else if (m_tready) begin
        m_tvalid <= 1'b0;
      end

      if (arm_q && has_header && s_fire) begin
        cfg_q.kernel_h <= s_tdata[conv_in_pkg::im_hdr_kh_word][conv_in_pkg::kh_bits-1:0];
        cfg_q.is_max   <= s_tdata[conv_in_pkg::im_hdr_flag_word][conv_in_pkg::im_hdr_max_bit];
        cfg_q.is_lrelu <= s_tdata[conv_in_pkg::im_hdr_flag_word][conv_in_pkg::im_hdr_lrelu_bit];
        arm_q          <= 1'b0;
      end else if (arm_q && !has_header && ready_en && !m_tvalid) begin
        arm_q <= 1'b0;  // One idle cycle lets the header of stream 1 settle.
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (data_fire) begin
      beat_q   <= s_tdata;
      m_tdata  <= window(s_tdata, kh_live, '0);
      m_kh_idx <= '0;
      m_last   <= s_tlast && (kh_live == conv_in_pkg::kh_t'(1));
    end else if (load_next) begin
      m_tdata  <= window(beat_q, kh_q, row_q);
      m_kh_idx <= row_q;
      m_last   <= last_q && final_row;
    end
  end

  a_kernel_h_legal: assert property (@(posedge aclk) disable iff (rst)
    data_fire |-> (kh_live == conv_in_pkg::kh_t'(1) || kh_live == conv_in_pkg::kh_t'(3)));

endmodule

`default_nettype wire

// ==== design/weights_rotator.sv ====
`default_nettype none

module weights_rotator (
  input  wire logic                 aclk,
  input  wire logic                 rst,
  input  wire logic                 s_tvalid,
  output logic                      s_tready,
  input  wire logic                 s_tlast,
  input  wire conv_in_pkg::w_beat_t s_tdata,
  output logic                      m_tvalid,
  input  wire logic                 m_tready,
  output conv_in_pkg::w_beat_t      m_tdata,
  output conv_in_pkg::kh_t          m_kh_idx,
  output logic                      m_is_cin_last,
  input  wire logic                 image_done
);

  typedef enum logic [1:0] {
    hdr,
    load,
    replay
  } rot_state_t;

  rot_state_t           state;
  logic                 ready_en;
  conv_in_pkg::w_beat_t mem [conv_in_pkg::w_depth];
  conv_in_pkg::cin_t    cin_q;
  conv_in_pkg::kh_t     kh_q;
  conv_in_pkg::w_addr_t last_addr;
  conv_in_pkg::w_addr_t wr_addr;
  conv_in_pkg::w_addr_t rd_addr;
  conv_in_pkg::cin_t    c_q;      // Channel of the next replayed row.
  conv_in_pkg::kh_t     r_q;      // Kernel row of the next replayed row.
  conv_in_pkg::w_hdr_t  hdr_view;
  conv_in_pkg::cin_t    hdr_cin;
  conv_in_pkg::kh_t     hdr_kh;
  conv_in_pkg::w_addr_t hdr_total;
  logic                 s_fire;
  logic                 rd_en;
  logic                 row_wrap;
  logic                 cin_wrap;

  assign hdr_view  = s_tdata;
  assign hdr_cin   = hdr_view.cin[conv_in_pkg::cin_bits-1:0];
  assign hdr_kh    = hdr_view.kernel_h[conv_in_pkg::kh_bits-1:0];
  assign hdr_total = conv_in_pkg::w_addr_t'(hdr_cin) * conv_in_pkg::w_addr_t'(hdr_kh);

  assign s_tready = ready_en && (state == hdr || state == load);
  assign s_fire   = s_tvalid && s_tready;
  assign rd_en    = (state == replay) && (!m_tvalid || m_tready) && !image_done;
  assign row_wrap = (r_q == kh_q - 1'b1);
  assign cin_wrap = (c_q == cin_q - 1'b1);

  always_ff @(posedge aclk) begin
    if (rst) begin
      state     <= hdr;
      ready_en  <= 1'b0;
      cin_q     <= '0;
      kh_q      <= '0;
      last_addr <= '0;
      wr_addr   <= '0;
      rd_addr   <= '0;
      c_q       <= '0;
      r_q       <= '0;
      m_tvalid  <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (image_done) begin
        state    <= hdr;   // Stored rows are released at the end of the image.
        m_tvalid <= 1'b0;
      end else begin
        case (state)
          hdr: begin
            if (s_fire) begin
              cin_q     <= hdr_cin;
              kh_q      <= hdr_kh;
              last_addr <= hdr_total - 1'b1;
              wr_addr   <= '0;
              state     <= load;
            end
          end
          load: begin
            if (s_fire) begin
              wr_addr <= wr_addr + 1'b1;
              if (wr_addr == last_addr) begin
                rd_addr <= '0;
                c_q     <= '0;
                r_q     <= '0;
                state   <= replay;
              end
            end
          end
          replay: begin
            if (rd_en) begin
              m_tvalid <= 1'b1;
              if (row_wrap) begin
                r_q <= '0;
                if (cin_wrap) begin
                  c_q     <= '0;
                  rd_addr <= '0;
                end else begin
                  c_q     <= c_q + 1'b1;
                  rd_addr <= rd_addr + 1'b1;
                end
              end else begin
                r_q     <= r_q + 1'b1;
                rd_addr <= rd_addr + 1'b1;
              end
            end
          end
          default: state <= hdr;
        endcase
      end
    end
  end

  // Rows are stored in arrival order, so the replay address is c * kernel_h + r.
  always_ff @(posedge aclk) begin
    if (state == load && s_fire) begin
      mem[wr_addr] <= s_tdata;
    end
    if (rd_en) begin
      m_tdata       <= mem[rd_addr];
      m_kh_idx      <= r_q;
      m_is_cin_last <= cin_wrap;
    end
  end

  a_tlast_on_last_row: assert property (@(posedge aclk) disable iff (rst)
    (state == load && s_fire) |-> (s_tlast == (wr_addr == last_addr)));

  a_cin_in_range: assert property (@(posedge aclk) disable iff (rst)
    (state == hdr && s_fire) |-> (hdr_view.cin != '0 && hdr_view.cin <= conv_in_pkg::cin_max));

endmodule

`default_nettype wire

// ==== design/conv_in_join.sv ====
`default_nettype none

module conv_in_join (
  input  wire logic                  aclk,
  input  wire logic                  rst,
  input  wire logic                  s1_tvalid,
  output logic                       s1_tready,
  input  wire conv_in_pkg::pix_out_t s1_tdata,
  input  wire conv_in_pkg::kh_t      s1_kh_idx,
  input  wire logic                  s1_last,
  input  wire logic                  s2_tvalid,
  output logic                       s2_tready,
  input  wire conv_in_pkg::pix_out_t s2_tdata,
  input  wire conv_in_pkg::kh_t      s2_kh_idx,
  input  wire logic                  w_tvalid,
  output logic                       w_tready,
  input  wire conv_in_pkg::w_beat_t  w_tdata,
  input  wire conv_in_pkg::kh_t      w_kh_idx,
  input  wire logic                  w_is_cin_last,
  input  wire conv_in_pkg::im_cfg_t  im_cfg,
  output logic                       m_tvalid,
  input  wire logic                  m_tready,
  output logic                       m_tlast,
  output conv_in_pkg::pix_out_t      m_pix1,
  output conv_in_pkg::pix_out_t      m_pix2,
  output conv_in_pkg::w_beat_t       m_weights,
  output conv_in_pkg::conv_user_t    m_tuser,
  output logic                       image_done
);

  logic                    all_valid;
  logic                    reg_free;
  logic                    take;
  conv_in_pkg::conv_user_t user_d;

  assign all_valid = s1_tvalid && s2_tvalid && w_tvalid;

  // The last beat of an image must leave before the next one is joined.
  assign reg_free  = !m_tvalid || (m_tready && !m_tlast);
  assign take      = all_valid && reg_free;

  assign s1_tready  = take;
  assign s2_tready  = take;
  assign w_tready   = take;
  assign image_done = m_tvalid && m_tready && m_tlast;

  always_comb begin
    user_d.is_max      = im_cfg.is_max;
    user_d.is_lrelu    = im_cfg.is_lrelu;
    user_d.is_1x1      = (im_cfg.kernel_h == conv_in_pkg::kh_t'(1));
    user_d.is_cin_last = w_is_cin_last;
    user_d.kh_idx      = w_kh_idx;
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_tvalid <= 1'b0;
    end else if (take) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      m_pix1    <= s1_tdata;
      m_pix2    <= s2_tdata;
      m_weights <= w_tdata;
      m_tuser   <= user_d;
      m_tlast   <= s1_last;
    end
  end

  a_rows_aligned: assert property (@(posedge aclk) disable iff (rst)
    take |-> (s1_kh_idx == s2_kh_idx && s1_kh_idx == w_kh_idx));

endmodule

`default_nettype wire

// ==== design/axis_input_pipe.sv ====
`default_nettype none

module axis_input_pipe (
  input  wire logic                  aclk,
  input  wire logic                  rst,
  input  wire logic                  s_pix1_tvalid,
  output logic                       s_pix1_tready,
  input  wire logic                  s_pix1_tlast,
  input  wire conv_in_pkg::pix_in_t  s_pix1_tdata,
  input  wire logic                  s_pix2_tvalid,
  output logic                       s_pix2_tready,
  input  wire logic                  s_pix2_tlast,
  input  wire conv_in_pkg::pix_in_t  s_pix2_tdata,
  input  wire logic                  s_w_tvalid,
  output logic                       s_w_tready,
  input  wire logic                  s_w_tlast,
  input  wire conv_in_pkg::w_beat_t  s_w_tdata,
  output logic                       m_out_tvalid,
  input  wire logic                  m_out_tready,
  output logic                       m_out_tlast,
  output conv_in_pkg::pix_out_t      m_out_pix1,
  output conv_in_pkg::pix_out_t      m_out_pix2,
  output conv_in_pkg::w_beat_t       m_out_weights,
  output conv_in_pkg::conv_user_t    m_out_tuser
);

  logic                  row1_tvalid;
  logic                  row1_tready;
  conv_in_pkg::pix_out_t row1_tdata;
  conv_in_pkg::kh_t      row1_kh_idx;
  logic                  row1_last;
  logic                  row2_tvalid;
  logic                  row2_tready;
  conv_in_pkg::pix_out_t row2_tdata;
  conv_in_pkg::kh_t      row2_kh_idx;
  logic                  rot_tvalid;
  logic                  rot_tready;
  conv_in_pkg::w_beat_t  rot_tdata;
  conv_in_pkg::kh_t      rot_kh_idx;
  logic                  rot_is_cin_last;
  conv_in_pkg::im_cfg_t  im_cfg;
  logic                  image_done;

  im_shifter #(.has_header(1'b1)) im_shift1 (
    .aclk(aclk), .rst(rst),
    .s_tvalid(s_pix1_tvalid), .s_tready(s_pix1_tready), .s_tlast(s_pix1_tlast),
    .s_tdata(s_pix1_tdata), .cfg_in('0),
    .m_tvalid(row1_tvalid), .m_tready(row1_tready), .m_tdata(row1_tdata),
    .m_kh_idx(row1_kh_idx), .m_last(row1_last), .cfg_out(im_cfg)
  );

  im_shifter #(.has_header(1'b0)) im_shift2 (
    .aclk(aclk), .rst(rst),
    .s_tvalid(s_pix2_tvalid), .s_tready(s_pix2_tready), .s_tlast(s_pix2_tlast),
    .s_tdata(s_pix2_tdata), .cfg_in(im_cfg),
    .m_tvalid(row2_tvalid), .m_tready(row2_tready), .m_tdata(row2_tdata),
    .m_kh_idx(row2_kh_idx), .m_last(), .cfg_out()
  );

  weights_rotator w_rot (
    .aclk(aclk), .rst(rst),
    .s_tvalid(s_w_tvalid), .s_tready(s_w_tready), .s_tlast(s_w_tlast), .s_tdata(s_w_tdata),
    .m_tvalid(rot_tvalid), .m_tready(rot_tready), .m_tdata(rot_tdata),
    .m_kh_idx(rot_kh_idx), .m_is_cin_last(rot_is_cin_last), .image_done(image_done)
  );

  conv_in_join join0 (
    .aclk(aclk), .rst(rst),
    .s1_tvalid(row1_tvalid), .s1_tready(row1_tready), .s1_tdata(row1_tdata),
    .s1_kh_idx(row1_kh_idx), .s1_last(row1_last),
    .s2_tvalid(row2_tvalid), .s2_tready(row2_tready), .s2_tdata(row2_tdata),
    .s2_kh_idx(row2_kh_idx),
    .w_tvalid(rot_tvalid), .w_tready(rot_tready), .w_tdata(rot_tdata),
    .w_kh_idx(rot_kh_idx), .w_is_cin_last(rot_is_cin_last), .im_cfg(im_cfg),
    .m_tvalid(m_out_tvalid), .m_tready(m_out_tready), .m_tlast(m_out_tlast),
    .m_pix1(m_out_pix1), .m_pix2(m_out_pix2), .m_weights(m_out_weights),
    .m_tuser(m_out_tuser), .image_done(image_done)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic aclk
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock with a 4 ns period.
  initial begin
    aclk = 1'b0;
    forever begin
      #2 aclk = ~aclk;
    end
  end

endmodule

`default_nettype wire

// ==== verif/axis_input_pipe_tb.sv ====
`default_nettype none

module axis_input_pipe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 2000;
  localparam int ready_len      = 1024;

  typedef struct packed {
    logic                 last;
    conv_in_pkg::pix_in_t data;
  } pix_beat_t;

  typedef struct packed {
    logic                 last;
    conv_in_pkg::w_beat_t data;
  } w_in_beat_t;

  typedef struct packed {
    conv_in_pkg::pix_out_t   pix1;
    conv_in_pkg::pix_out_t   pix2;
    conv_in_pkg::w_beat_t    weights;
    conv_in_pkg::conv_user_t user;
    logic                    last;
  } out_beat_t;

  logic                    aclk;
  logic                    rst;
  logic                    s_pix1_tvalid;
  logic                    s_pix1_tready;
  logic                    s_pix1_tlast;
  conv_in_pkg::pix_in_t    s_pix1_tdata;
  logic                    s_pix2_tvalid;
  logic                    s_pix2_tready;
  logic                    s_pix2_tlast;
  conv_in_pkg::pix_in_t    s_pix2_tdata;
  logic                    s_w_tvalid;
  logic                    s_w_tready;
  logic                    s_w_tlast;
  conv_in_pkg::w_beat_t    s_w_tdata;
  logic                    m_out_tvalid;
  logic                    m_out_tready;
  logic                    m_out_tlast;
  conv_in_pkg::pix_out_t   m_out_pix1;
  conv_in_pkg::pix_out_t   m_out_pix2;
  conv_in_pkg::w_beat_t    m_out_weights;
  conv_in_pkg::conv_user_t m_out_tuser;

  pix_beat_t  pix1_q[$];
  pix_beat_t  pix2_q[$];
  w_in_beat_t w_q[$];
  out_beat_t  exp_q[$];
  out_beat_t  got_q[$];
  bit         ready_pattern[ready_len];
  int         ready_idx;
  bit         random_ready;
  bit         pix1_hdr_done;

  tb_clock_gen clk_gen (.aclk(aclk));

  axis_input_pipe dut0 (
    .aclk(aclk), .rst(rst),
    .s_pix1_tvalid(s_pix1_tvalid), .s_pix1_tready(s_pix1_tready),
    .s_pix1_tlast(s_pix1_tlast), .s_pix1_tdata(s_pix1_tdata),
    .s_pix2_tvalid(s_pix2_tvalid), .s_pix2_tready(s_pix2_tready),
    .s_pix2_tlast(s_pix2_tlast), .s_pix2_tdata(s_pix2_tdata),
    .s_w_tvalid(s_w_tvalid), .s_w_tready(s_w_tready),
    .s_w_tlast(s_w_tlast), .s_w_tdata(s_w_tdata),
    .m_out_tvalid(m_out_tvalid), .m_out_tready(m_out_tready), .m_out_tlast(m_out_tlast),
    .m_out_pix1(m_out_pix1), .m_out_pix2(m_out_pix2),
    .m_out_weights(m_out_weights), .m_out_tuser(m_out_tuser)
  );

  always @(negedge aclk) begin
    if (rst || !random_ready) begin
      m_out_tready = !rst;
    end else begin
      m_out_tready = ready_pattern[ready_idx % ready_len];
      ready_idx++;
    end
  end

  always @(posedge aclk) begin : monitor
    out_beat_t beat;
    if (!rst && m_out_tvalid && m_out_tready) begin
      beat.pix1    = m_out_pix1;
      beat.pix2    = m_out_pix2;
      beat.weights = m_out_weights;
      beat.user    = m_out_tuser;
      beat.last    = m_out_tlast;
      got_q.push_back(beat);
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failed check.");
  endtask

  task automatic compare_pix(input string name, input conv_in_pkg::pix_out_t exp_v,
                             input conv_in_pkg::pix_out_t act_v);
    if (act_v !== exp_v) begin
      report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic compare_weights(input string name, input conv_in_pkg::w_beat_t exp_v,
                                 input conv_in_pkg::w_beat_t act_v);
    if (act_v !== exp_v) begin
      report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic compare_user(input string name, input conv_in_pkg::conv_user_t exp_v,
                              input logic exp_last, input conv_in_pkg::conv_user_t act_v,
                              input logic act_last);
    if (act_v !== exp_v) begin
      report_failure($sformatf("MISMATCH %s m_out_tuser expected %h actual %h",
                               name, exp_v, act_v));
    end
    if (act_last !== exp_last) begin
      report_failure($sformatf("MISMATCH %s m_out_tlast expected %h actual %h",
                               name, exp_last, act_last));
    end
  endtask

  // Row r of a 3x3 kernel reads words r and r+1, a 1x1 kernel reads words 1 and 2.
  function automatic conv_in_pkg::pix_out_t expected_row(input conv_in_pkg::pix_in_t beat,
                                                         input int kh, input int r);
    conv_in_pkg::pix_out_t row;
    int                    first;
    first = (kh == 1) ? 1 : r;
    for (int u = 0; u < conv_in_pkg::units; u++) begin
      row[u] = beat[first + u];
    end
    return row;
  endfunction

  function automatic conv_in_pkg::pix_in_t random_pix();
    conv_in_pkg::pix_in_t beat;
    for (int i = 0; i < conv_in_pkg::units_edges; i++) begin
      beat[i] = conv_in_pkg::word_t'($urandom);
    end
    return beat;
  endfunction

  function automatic conv_in_pkg::w_beat_t random_w();
    conv_in_pkg::w_beat_t beat;
    for (int i = 0; i < conv_in_pkg::w_beat_words; i++) begin
      beat[i] = conv_in_pkg::word_t'($urandom);
    end
    return beat;
  endfunction

  task automatic clear_queues();
    pix1_q.delete();
    pix2_q.delete();
    w_q.delete();
    exp_q.delete();
    got_q.delete();
  endtask

  // Queues the input beats of one image and the output beats that it should give.
  task automatic queue_image(input int kh, input int cin, input int cols,
                             input bit is_max, input bit is_lrelu);
    conv_in_pkg::w_beat_t rows[$];
    pix_beat_t            b1;
    pix_beat_t            b2;
    w_in_beat_t           wb;
    out_beat_t            e;
    int                   n_beats;
    n_beats = cols * cin;
    wb = '0;
    wb.data[0] = conv_in_pkg::word_t'(cin);
    wb.data[1] = conv_in_pkg::word_t'(kh);
    w_q.push_back(wb);
    for (int i = 0; i < cin * kh; i++) begin
      wb.data = random_w();
      wb.last = (i == cin * kh - 1);
      w_q.push_back(wb);
      rows.push_back(wb.data);
    end
    b1 = '0;
    b1.data[0] = conv_in_pkg::word_t'(kh);
    b1.data[1] = conv_in_pkg::word_t'({is_lrelu, is_max});
    pix1_q.push_back(b1);
    for (int d = 0; d < n_beats; d++) begin
      b1.data = random_pix();
      b1.last = (d == n_beats - 1);
      b2.data = random_pix();
      b2.last = b1.last;
      pix1_q.push_back(b1);
      pix2_q.push_back(b2);
      for (int r = 0; r < kh; r++) begin
        e.pix1             = expected_row(b1.data, kh, r);
        e.pix2             = expected_row(b2.data, kh, r);
        e.weights          = rows[(d % cin) * kh + r];  // Channels vary fastest.
        e.user.is_max      = is_max;
        e.user.is_lrelu    = is_lrelu;
        e.user.is_1x1      = (kh == 1);
        e.user.is_cin_last = (d % cin == cin - 1);
        e.user.kh_idx      = conv_in_pkg::kh_t'(r);
        e.last             = b1.last && (r == kh - 1);
        exp_q.push_back(e);
      end
    end
  endtask

  function automatic logic ready_of(input int stream);
    case (stream)
      0: return s_pix1_tready;
      1: return s_pix2_tready;
      default: return s_w_tready;
    endcase
  endfunction

  task automatic wait_accept(input int stream, input string name);
    int waited;
    waited = 0;
    do begin
      @(posedge aclk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure($sformatf("Timed out waiting for %s to accept a beat.", name));
      end
    end while (!ready_of(stream));
  endtask

  task automatic send_pix1();
    while (pix1_q.size() > 0) begin
      @(negedge aclk);
      s_pix1_tvalid = 1'b1;
      s_pix1_tdata  = pix1_q[0].data;
      s_pix1_tlast  = pix1_q[0].last;
      wait_accept(0, "s_pix1");
      void'(pix1_q.pop_front());
      pix1_hdr_done = 1'b1;
    end
    @(negedge aclk);
    s_pix1_tvalid = 1'b0;
  endtask

  task automatic send_pix2();
    int waited;
    waited = 0;
    while (!pix1_hdr_done) begin  // Stream 2 uses the config from the stream 1 header.
      @(negedge aclk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure("Timed out waiting for the pixel header to be taken.");
      end
    end
    while (pix2_q.size() > 0) begin
      @(negedge aclk);
      s_pix2_tvalid = 1'b1;
      s_pix2_tdata  = pix2_q[0].data;
      s_pix2_tlast  = pix2_q[0].last;
      wait_accept(1, "s_pix2");
      void'(pix2_q.pop_front());
    end
    @(negedge aclk);
    s_pix2_tvalid = 1'b0;
  endtask

  task automatic send_w();
    while (w_q.size() > 0) begin
      @(negedge aclk);
      s_w_tvalid = 1'b1;
      s_w_tdata  = w_q[0].data;
      s_w_tlast  = w_q[0].last;
      wait_accept(2, "s_w");
      void'(w_q.pop_front());
    end
    @(negedge aclk);
    s_w_tvalid = 1'b0;
  endtask

  // Sends all queued images, collects the output and compares it beat by beat.
  task automatic run_queued(input bit rand_ready);
    int waited;
    random_ready  = rand_ready;
    pix1_hdr_done = 1'b0;
    fork
      send_pix1();
      send_pix2();
      send_w();
    join
    waited = 0;
    while (got_q.size() < exp_q.size()) begin
      @(negedge aclk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure("Timed out waiting for the output beats.");
      end
    end
    repeat (20) @(negedge aclk);  // Room for any extra beat to show up.
    if (got_q.size() != exp_q.size()) begin
      report_failure($sformatf("Got %0d output beats where %0d were expected.",
                               got_q.size(), exp_q.size()));
    end
    for (int i = 0; i < exp_q.size(); i++) begin
      compare_pix($sformatf("beat %0d m_out_pix1", i), exp_q[i].pix1, got_q[i].pix1);
      compare_pix($sformatf("beat %0d m_out_pix2", i), exp_q[i].pix2, got_q[i].pix2);
      compare_weights($sformatf("beat %0d m_out_weights", i), exp_q[i].weights,
                      got_q[i].weights);
      compare_user($sformatf("beat %0d", i), exp_q[i].user, exp_q[i].last,
                   got_q[i].user, got_q[i].last);
    end
    random_ready = 1'b0;
  endtask

  task automatic check_tlast_count(input int images);
    int n_last;
    n_last = 0;
    foreach (got_q[i]) begin
      if (got_q[i].last) begin
        n_last++;
      end
    end
    if (n_last != images || !got_q[got_q.size() - 1].last) begin
      report_failure($sformatf("Saw tlast %0d times for %0d images.", n_last, images));
    end
  endtask

  task automatic test_3x3();
    clear_queues();
    queue_image(3, 2, 2, 1'b0, 1'b0);
    run_queued(1'b0);
  endtask

  task automatic test_1x1();
    clear_queues();
    queue_image(1, 2, 3, 1'b1, 1'b1);
    run_queued(1'b0);
  endtask

  task automatic test_backpressure();
    clear_queues();
    queue_image(3, 2, 2, 1'b0, 1'b0);
    run_queued(1'b1);
  endtask

  task automatic test_tlast();
    clear_queues();
    queue_image(3, 1, 3, 1'b0, 1'b1);
    run_queued(1'b1);
    check_tlast_count(1);
  endtask

  task automatic test_back_to_back();
    clear_queues();
    queue_image(3, 2, 2, 1'b0, 1'b0);
    queue_image(1, 3, 2, 1'b1, 1'b0);  // New weight header with other rows.
    run_queued(1'b0);
    check_tlast_count(2);
  endtask

  initial begin
    void'($urandom(32'hb5ab7db7));
    for (int i = 0; i < ready_len; i++) begin
      ready_pattern[i] = 1'($urandom_range(0, 1));
    end
    ready_idx     = 0;
    random_ready  = 1'b0;
    pix1_hdr_done = 1'b0;
    rst           = 1'b1;
    s_pix1_tvalid = 1'b0;
    s_pix1_tlast  = 1'b0;
    s_pix1_tdata  = '0;
    s_pix2_tvalid = 1'b0;
    s_pix2_tlast  = 1'b0;
    s_pix2_tdata  = '0;
    s_w_tvalid    = 1'b0;
    s_w_tlast     = 1'b0;
    s_w_tdata     = '0;
    m_out_tready  = 1'b0;
    repeat (8) @(negedge aclk);
    rst = 1'b0;

    test_3x3();
    test_1x1();
    test_backpressure();
    test_tlast();
    test_back_to_back();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/conv_in_pkg.sv
design/im_shifter.sv
design/weights_rotator.sv
design/conv_in_join.sv
design/axis_input_pipe.sv
verif/tb_clock_gen.sv
verif/axis_input_pipe_tb.sv
